// ==== vlog.f ====
audio_pkg.sv
sample_fifo.sv
audio_clk_gen.sv
audio_regs.sv
i2s_tx.sv
audio_top.sv
audio_checker.sv
tb_audio.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_audio
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_audio.sv ====
`timescale 1ns/1ns

module tb_audio
    import audio_pkg::*;
();

    localparam int FIFO_DEPTH   = 8;
    localparam int CLK_PERIOD   = 20;
    localparam int FRAME_CYCLES = 512;
    localparam int MAX_FRAMES   = 600;
    localparam int ACK_LIMIT    = 16;
    localparam int DRAIN_LIMIT  = 2 * FIFO_DEPTH + 4;

    logic     clk_100mhz;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    logic     audio_mclk;
    logic     audio_lrck;
    logic     audio_sck;
    logic     audio_sdin;

    string test_name = "none";
    int    tb_errors = 0;
    int    errs_at_start = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;

    audio_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

    audio_checker #(.FIFO_DEPTH(FIFO_DEPTH)) chk0 (
        .clk_100mhz(clk_100mhz), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack),
        .audio_mclk(audio_mclk), .audio_lrck(audio_lrck), .audio_sck(audio_sck),
        .audio_sdin(audio_sdin)
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #(CLK_PERIOD / 2) clk_100mhz = ~clk_100mhz;
    end

    // Watchdog
    initial begin
        #(MAX_FRAMES * FRAME_CYCLES * CLK_PERIOD);
        $display("Run hung: tests did not finish within %0d frames", MAX_FRAMES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus and sequencing tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             output wb_data_t rdat);
        int waited;
        waited = 0;
        @(posedge clk_100mhz);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        do begin
            @(posedge clk_100mhz);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            tb_errors++;
            $display("Bus cycle to address %0d got no ack in %0d cycles", adr, ACK_LIMIT);
        end
        rdat = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused_rd;
        bus_cycle(1'b1, adr, dat, unused_rd);
    endtask

    task automatic bus_read(input wb_addr_t adr, output wb_data_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic check_reg(input wb_addr_t adr, input wb_data_t exp);
        wb_data_t act;
        bus_read(adr, act);
        if (act !== exp) begin
            tb_errors++;
            $display("ERROR %s: register %0d expected %h actual %h", test_name, adr, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            tb_errors++;
            $display("ERROR %s: %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(negedge audio_lrck);
    endtask

    // CTRL writes land just after a frame boundary
    task automatic set_ctrl(input wb_data_t val);
        wait_frames(1);
        bus_write(ADDR_CTRL, val);
    endtask

    task automatic write_pair(input logic negative);
        wb_data_t pair;
        pair = $urandom;
        if (negative) begin
            pair = pair | 32'h8000_8000;
        end
        bus_write(ADDR_SAMPLE, pair);
    endtask

    // Poll STATUS once per frame until the FIFO reports empty
    task automatic wait_drain();
        wb_data_t stat;
        int       guard;
        guard = 0;
        bus_read(ADDR_STATUS, stat);
        while (!stat[STAT_EMPTY] && guard < DRAIN_LIMIT) begin
            wait_frames(1);
            guard++;
            bus_read(ADDR_STATUS, stat);
        end
        if (!stat[STAT_EMPTY]) begin
            tb_errors++;
            $display("FIFO still held pairs after %0d frames", DRAIN_LIMIT);
        end
        wait_frames(1);
    endtask

    // Fill while disabled, then enable and let every pair play out
    task automatic run_stream(input wb_data_t ctrl, input int count, input logic negative);
        int base;
        base = chk0.frames_checked;
        set_ctrl(ctrl);
        repeat (count) write_pair(negative);
        set_ctrl(ctrl | 32'h1);
        wait_drain();
        set_ctrl(ctrl);
        check_count("data frames", count, chk0.frames_checked - base);
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        chk0.test_name = name;
        errs_at_start  = tb_errors + chk0.err_count;
    endtask

    task automatic end_test();
        int errs;
        errs = tb_errors + chk0.err_count - errs_at_start;
        if (errs == 0) begin
            pass_cnt++;
            $display("Test %s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("Test %s: failed with %0d errors", test_name, errs);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        wb_data_t val;
        int       base;
        void'($urandom(32'he1a4));
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (16) @(posedge clk_100mhz);
        rst_n <= 1'b1;

        begin_test("reset_state");
        check_reg(ADDR_CTRL, '0);
        check_reg(ADDR_STATUS, 32'h100);
        check_reg(ADDR_UNDERRUN, '0);
        wait_frames(3);
        end_test();

        begin_test("plain_streaming");
        run_stream(32'h0, 6, 1'b0);
        end_test();

        // Atten 3 on negative samples, then mute
        begin_test("scaling");
        run_stream(32'h0c, 6, 1'b1);
        run_stream(32'h02, 6, 1'b0);
        end_test();

        begin_test("overflow");
        set_ctrl(32'h0);
        repeat (FIFO_DEPTH + 3) write_pair(1'b0);
        check_reg(ADDR_STATUS, wb_data_t'(FIFO_DEPTH) | 32'h600);
        base = chk0.frames_checked;
        set_ctrl(32'h1);
        wait_drain();
        wait_frames(2);
        set_ctrl(32'h0);
        check_count("frames from a full FIFO", FIFO_DEPTH, chk0.frames_checked - base);
        end_test();

        begin_test("underrun");
        set_ctrl(32'h1);
        wait_frames(4);
        set_ctrl(32'h0);
        bus_read(ADDR_UNDERRUN, val);
        if (val < 32'd3 || val > 32'hffff) begin
            tb_errors++;
            $display("ERROR %s: underrun count expected 3 to 65535 actual %0d",
                     test_name, val);
        end
        bus_write(ADDR_UNDERRUN, '0);
        check_reg(ADDR_UNDERRUN, '0);
        check_reg(ADDR_STATUS, 32'h100);
        end_test();

        $display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && tb_errors + chk0.err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== audio_checker.sv ====
`timescale 1ns/1ns

module audio_checker
    import audio_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input logic     clk_100mhz,
    input logic     rst_n,
    input logic     wb_cyc,
    input logic     wb_stb,
    input logic     wb_we,
    input wb_addr_t wb_adr,
    input wb_data_t wb_dat_w,
    input logic     wb_ack,
    input logic     audio_mclk,
    input logic     audio_lrck,
    input logic     audio_sck,
    input logic     audio_sdin
);

    // One written pair and the CTRL bits in force at its write
    typedef struct packed {
        stereo_t    pair;
        logic [4:0] ctrl;
    } entry_t;

    entry_t      pending[$];
    entry_t      fresh;
    entry_t      head;
    logic [4:0]  ctrl_model = '0;
    logic        prev_sck = 1'b0;
    logic        prev_lrck = 1'b0;
    logic        in_frame = 1'b0;
    logic        expect_data = 1'b0;
    stereo_t     expected = '0;
    logic [31:0] frame = '0;
    int          bit_cnt = 0;
    int unsigned ticks = 0;
    logic [2:0]  exp_clks = '0;
    logic        clk_err = 1'b0;

    // Shared with the testbench top
    string test_name = "none";
    int    err_count = 0;
    int    frames_checked = 0;

    // Mute gives silence, otherwise each half shifts down by atten (CTRL bits 4 to 2)
    function automatic stereo_t expected_pair(input stereo_t p, input logic [4:0] ctrl);
        stereo_t r;
        if (ctrl[1]) begin
            r = '0;
        end else begin
            r.left  = $signed(p.left) >>> ctrl[4:2];
            r.right = $signed(p.right) >>> ctrl[4:2];
        end
        return r;
    endfunction

    task automatic compare_frame();
        if (expect_data) begin
            frames_checked++;
            if (frame !== wb_data_t'(expected)) begin
                err_count++;
                $display("ERROR %s: frame expected %h actual %h", test_name,
                         wb_data_t'(expected), frame);
            end
        end else if (frame !== '0) begin
            err_count++;
            $display("ERROR %s: frame expected %h actual %h", test_name, 32'h0, frame);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus and serial monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_100mhz) begin
        if (rst_n) begin
            // DAC clocks low for the first half of each period from reset
            exp_clks = {(ticks % 512) >= 256, (ticks % 16) >= 8, (ticks % 4) >= 2};
            if (!clk_err && {audio_lrck, audio_sck, audio_mclk} !== exp_clks) begin
                clk_err = 1'b1;
                err_count++;
                $display("ERROR %s: DAC clocks lrck sck mclk expected %b actual %b",
                         test_name, exp_clks, {audio_lrck, audio_sck, audio_mclk});
            end
            ticks++;

            // Acked writes, data is still held by the master
            if (wb_ack && wb_cyc && wb_stb && wb_we) begin
                if (wb_adr == ADDR_CTRL) begin
                    ctrl_model = wb_dat_w[4:0];
                end else if (wb_adr == ADDR_SAMPLE) begin
                    fresh.pair = stereo_t'(wb_dat_w);
                    fresh.ctrl = ctrl_model;
                    // A write to a full FIFO is dropped
                    if (pending.size() < FIFO_DEPTH) begin
                        pending.push_back(fresh);
                    end
                end
            end

            // Falling lrck, the transmitter has just taken its pair
            if (prev_lrck && !audio_lrck) begin
                in_frame = 1'b1;
                bit_cnt  = 0;
                frame    = '0;
                expect_data = ctrl_model[0] && (pending.size() > 0);
                if (expect_data) begin
                    head     = pending.pop_front();
                    expected = expected_pair(head.pair, head.ctrl);
                end
            end

            // Data is stable at rising sck
            if (in_frame && audio_sck && !prev_sck) begin
                frame = {frame[30:0], audio_sdin};
                bit_cnt++;
                if (bit_cnt == 32) begin
                    in_frame = 1'b0;
                    compare_frame();
                end
            end
        end else begin
            ticks = 0;
        end
        prev_sck  = audio_sck;
        prev_lrck = audio_lrck;
    end

endmodule

// ==== audio_top.sv ====
`timescale 1ns/1ns

module audio_top
    import audio_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic     clk_100mhz,
    input  logic     rst_n,
    // Host bus
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    // DAC pins
    output logic     audio_mclk,
    output logic     audio_lrck,
    output logic     audio_sck,
    output logic     audio_sdin
);

    logic       push;
    stereo_t    push_data;
    logic       pop;
    stereo_t    pop_data;
    logic       empty;
    logic       full;
    level_t     level;
    audio_cfg_t cfg;
    logic       underrun;
    logic       bit_fall;
    logic       frame_start;

    audio_regs #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_regs (
        .clk_100mhz(clk_100mhz),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .level     (level),
        .empty     (empty),
        .full      (full),
        .underrun  (underrun),
        .push      (push),
        .push_data (push_data),
        .cfg       (cfg)
    );

    sample_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk_100mhz(clk_100mhz),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty),
        .full      (full),
        .level     (level)
    );

    audio_clk_gen u_clk_gen (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .audio_mclk (audio_mclk),
        .audio_sck  (audio_sck),
        .audio_lrck (audio_lrck),
        .bit_fall   (bit_fall),
        .frame_start(frame_start)
    );

    i2s_tx u_tx (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .bit_fall   (bit_fall),
        .frame_start(frame_start),
        .cfg        (cfg),
        .pop_data   (pop_data),
        .empty      (empty),
        .pop        (pop),
        .underrun   (underrun),
        .audio_sdin (audio_sdin)
    );

endmodule

// ==== i2s_tx.sv ====
`timescale 1ns/1ns

module i2s_tx
    import audio_pkg::*;
(
    input  logic       clk_100mhz,
    input  logic       rst_n,
    input  logic       bit_fall,
    input  logic       frame_start,
    input  audio_cfg_t cfg,
    input  stereo_t    pop_data,
    input  logic       empty,
    output logic       pop,
    output logic       underrun,
    output logic       audio_sdin
);

    // Shifts left after the first bit of a frame
    localparam logic [4:0] LAST_SHIFT = 5'd30;

    tx_state_t   state;
    logic [31:0] shreg;
    logic [4:0]  bit_idx;
    stereo_t     scaled;

    // Mute to zero, otherwise arithmetic shift down
    function automatic sample_t scale_sample(input sample_t s, input audio_cfg_t c);
        sample_t r;
        if (c.mute) begin
            r = '0;
        end else begin
            r = s >>> c.atten;
        end
        return r;
    endfunction

    always_comb begin
        scaled.left  = scale_sample(pop_data.left, cfg);
        scaled.right = scale_sample(pop_data.right, cfg);
    end

    // Head of FIFO leaves in the frame_start cycle
    assign pop = frame_start && cfg.enable && !empty;

    ////////////////////////////////////////////////////////////////////////////
    // Serializer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            state    <= IDLE;
            shreg    <= '0;
            bit_idx  <= '0;
            underrun <= 1'b0;
        end else begin
            underrun <= frame_start && cfg.enable && empty;

            if (frame_start) begin
                // Load on the same edge that drops lrck and sck
                bit_idx <= '0;
                if (!cfg.enable) begin
                    state <= IDLE;
                    shreg <= '0;
                end else begin
                    state <= SHIFT;
                    shreg <= empty ? '0 : scaled;
                end
            end else if (bit_fall && state == SHIFT) begin
                shreg   <= {shreg[30:0], 1'b0};
                bit_idx <= bit_idx + 5'd1;
                // Right LSB now on the pin until the next frame
                if (bit_idx == LAST_SHIFT) begin
                    state <= LOAD;
                end
            end
        end
    end

    assign audio_sdin = shreg[31];

    // Divider and bit count stay in step
    a_frame_aligned: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        frame_start |-> state != SHIFT);

    a_pop_starts_frame: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        pop |=> state == SHIFT && bit_idx == '0);

endmodule

// ==== audio_regs.sv ====
`timescale 1ns/1ns

module audio_regs
    import audio_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       clk_100mhz,
    input  logic       rst_n,
    // Wishbone classic slave
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_addr_t   wb_adr,
    input  wb_data_t   wb_dat_w,
    output wb_data_t   wb_dat_r,
    output logic       wb_ack,
    // FIFO status and transmitter events
    input  level_t     level,
    input  logic       empty,
    input  logic       full,
    input  logic       underrun,
    // Sample push and control
    output logic       push,
    output stereo_t    push_data,
    output audio_cfg_t cfg
);

    logic      req;
    logic      wr_req;
    logic      wr_sample;
    logic      wr_ctrl;
    logic      wr_urun;
    logic      overflow;
    urun_cnt_t urun_cnt;
    wb_data_t  rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////////////////////

    // New cycle seen while ack is still low
    assign req       = wb_cyc && wb_stb && !wb_ack;
    assign wr_req    = req && wb_we;
    assign wr_ctrl   = wr_req && (wb_adr == ADDR_CTRL);
    assign wr_sample = wr_req && (wb_adr == ADDR_SAMPLE);
    assign wr_urun   = wr_req && (wb_adr == ADDR_UNDERRUN);

    // Read mux, SAMPLE reads back as zero
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            ADDR_CTRL: begin
                rd_data[0]   = cfg.enable;
                rd_data[1]   = cfg.mute;
                rd_data[4:2] = cfg.atten;
            end
            ADDR_STATUS: begin
                rd_data[7:0]          = level;
                rd_data[STAT_EMPTY]    = empty;
                rd_data[STAT_FULL]     = full;
                rd_data[STAT_OVERFLOW] = overflow;
            end
            ADDR_UNDERRUN: begin
                rd_data[15:0] = urun_cnt;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            push     <= 1'b0;
            cfg      <= '0;
            overflow <= 1'b0;
            urun_cnt <= '0;
        end else begin
            wb_ack <= req;
            // Writes to a full FIFO are acked but dropped
            push   <= wr_sample && !full;

            if (wr_ctrl) begin
                cfg.enable <= wb_dat_w[0];
                cfg.mute   <= wb_dat_w[1];
                cfg.atten  <= wb_dat_w[4:2];
            end

            // Any UNDERRUN write clears both error records
            if (wr_urun) begin
                overflow <= 1'b0;
                urun_cnt <= '0;
            end else begin
                if (wr_sample && full) begin
                    overflow <= 1'b1;
                end
                if (underrun && urun_cnt != '1) begin
                    urun_cnt <= urun_cnt + 16'd1;
                end
            end
        end
    end

    // Read data and sample payload
    always_ff @(posedge clk_100mhz) begin
        if (req) begin
            wb_dat_r <= rd_data;
        end
        if (wr_sample) begin
            push_data <= stereo_t'(wb_dat_w);
        end
    end

    a_ack_single: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

    a_level_bound: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        level <= level_t'(FIFO_DEPTH));

endmodule

// ==== audio_clk_gen.sv ====
`timescale 1ns/1ns

module audio_clk_gen (
    input  logic clk_100mhz,
    input  logic rst_n,
    output logic audio_mclk,
    output logic audio_sck,
    output logic audio_lrck,
    output logic bit_fall,
    output logic frame_start
);

    localparam int CNT_W = 9;

    // Counter bits that become the DAC clocks
    localparam int MCLK_BIT = 1;
    localparam int SCK_BIT  = 3;
    localparam int LRCK_BIT = 8;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_next;

    assign cnt_next = cnt + 9'd1;

    ////////////////////////////////////////////////////////////////////////////
    // Free running divider
    ////////////////////////////////////////////////////////////////////////////

    // Registered taps follow the counter value exactly
    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            cnt        <= '0;
            audio_mclk <= 1'b0;
            audio_sck  <= 1'b0;
            audio_lrck <= 1'b0;
        end else begin
            cnt        <= cnt_next;
            audio_mclk <= cnt_next[MCLK_BIT];
            audio_sck  <= cnt_next[SCK_BIT];
            audio_lrck <= cnt_next[LRCK_BIT];
        end
    end

    // sck falls on the edge after the low nibble reaches 15
    assign bit_fall = (cnt[SCK_BIT:0] == 4'hf);

    // Last cycle of the frame, lrck falls on the next edge
    assign frame_start = (cnt == 9'h1ff);

    a_frame_on_bit: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        frame_start |-> bit_fall ##1 $fell(audio_lrck));

    a_bit_fall_sck: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        bit_fall |=> $fell(audio_sck));

endmodule

// ==== sample_fifo.sv ====
`timescale 1ns/1ns

module sample_fifo
    import audio_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic    clk_100mhz,
    input  logic    rst_n,
    input  logic    push,
    input  stereo_t push_data,
    input  logic    pop,
    output stereo_t pop_data,
    output logic    empty,
    output logic    full,
    output level_t  level
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    localparam ptr_t LAST_PTR = ptr_t'(FIFO_DEPTH - 1);

    stereo_t mem [FIFO_DEPTH];
    ptr_t    wr_ptr;
    ptr_t    rd_ptr;
    level_t  count;
    logic    do_push;
    logic    do_pop;

    // Level is only 8 bits wide
    if (FIFO_DEPTH < 1 || FIFO_DEPTH > 255) begin : g_depth_check
        $error("sample_fifo: FIFO_DEPTH must be between 1 and 255");
    end

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Storage
    always_ff @(posedge clk_100mhz) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge clk_100mhz) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : ptr_t'(wr_ptr + 1'b1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : ptr_t'(rd_ptr + 1'b1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 8'd1;
                2'b01:   count <= count - 8'd1;
                default: count <= count;
            endcase
        end
    end

    // Head entry is always visible
    assign pop_data = mem[rd_ptr];
    assign level    = count;
    assign empty    = (count == '0);
    assign full     = (count == level_t'(FIFO_DEPTH));

    a_no_pop_empty: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        pop |-> !empty);

    a_no_push_full: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        push |-> !full);

endmodule

// ==== audio_pkg.sv ====
package audio_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Audio data types
    ////////////////////////////////////////////////////////////////////////////

    // One signed PCM sample
    typedef logic signed [15:0] sample_t;

    // Stereo pair, left in the upper half like the bus data word
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    // Attenuation as an arithmetic right shift
    typedef logic [2:0] atten_t;

    // FIFO fill level, depth limited to 255
    typedef logic [7:0] level_t;

    // Saturating underrun counter
    typedef logic [15:0] urun_cnt_t;

    // Control bits from the register block to the transmitter
    typedef struct packed {
        logic   enable;
        logic   mute;
        atten_t atten;
    } audio_cfg_t;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone register map
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] wb_data_t;
    typedef logic [1:0]  wb_addr_t;

    localparam wb_addr_t ADDR_CTRL     = 2'd0;
    localparam wb_addr_t ADDR_SAMPLE   = 2'd1;
    localparam wb_addr_t ADDR_STATUS   = 2'd2;
    localparam wb_addr_t ADDR_UNDERRUN = 2'd3;

    // STATUS flag positions above the level field
    localparam int STAT_EMPTY    = 8;
    localparam int STAT_FULL     = 9;
    localparam int STAT_OVERFLOW = 10;

    // Serializer FSM
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SHIFT
    } tx_state_t;

endpackage
